//--- uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// ****************************************
// build-time settings of the receiver.
// ****************************************

`define UART_CLK_FREQ   50_000_000 // system clock in Hz.
`define UART_BAUD_RATE  5_000_000  // gives 10 clocks per bit.
`define UART_DATA_WIDTH 8

// entries per FIFO, must be a power of two.
`define UART_FIFO_DEPTH 4

`endif

//--- uart_pkg.sv
`include "uart_params.svh"

package uart_pkg;

    // ****************************************
    // frame types
    // ****************************************

    // one received character as it leaves a receiver.
    typedef struct packed {
        logic [`UART_DATA_WIDTH-1:0] data;
        logic                        frame_err; // stop bit was sampled low.
    } rx_frame_t;

    // a received character together with the line it came from.
    typedef struct packed {
        logic      chan;  // 0 for rx_i[0], 1 for rx_i[1].
        rx_frame_t frame;
    } tagged_frame_t;

endpackage

//--- uart_rx.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx (
    input  logic                clk_i,
    input  logic                arstn_i,
    input  logic                rx_i,
    output uart_pkg::rx_frame_t frame_o,
    output logic                frame_valid_o
);

    import uart_pkg::*;

    localparam int CLKS_PER_BIT = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int BAUD_W       = $clog2(CLKS_PER_BIT);
    localparam int BIT_W        = $clog2(`UART_DATA_WIDTH);

    typedef enum logic [2:0] {
        IDLE  = 3'b000,
        START = 3'b001,
        DATA  = 3'b010,
        STOP  = 3'b011,
        WAIT  = 3'b100
    } state_t;

    state_t                      state;
    logic [1:0]                  rx_sync;
    logic                        rx_s;
    logic [BAUD_W-1:0]           baud_cnt;
    logic [BIT_W-1:0]            bit_cnt;
    logic [`UART_DATA_WIDTH-1:0] shift_q;
    rx_frame_t                   frame_q;
    logic                        start_smp;
    logic                        bit_smp;
    logic                        last_bit;

    // ****************************************
    // line synchronizer
    // ****************************************

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rx_sync <= 2'b11; // an idle line is high.
        end else begin
            rx_sync <= {rx_sync[0], rx_i};
        end
    end

    assign rx_s = rx_sync[1];

    // the start bit is checked in its middle, later bits one bit time apart.
    assign start_smp = (state == START) && (baud_cnt == BAUD_W'(HALF_BIT - 1));
    assign bit_smp   = ((state == DATA) || (state == STOP)) &&
                       (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));
    assign last_bit  = (bit_cnt == BIT_W'(`UART_DATA_WIDTH - 1));

    // ****************************************
    // frame engine
    // ****************************************

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (!rx_s) begin
                        state <= START;
                    end
                end
                START: begin
                    if (start_smp) begin
                        state <= rx_s ? IDLE : DATA; // a high line here was a glitch.
                    end
                end
                DATA: begin
                    if (bit_smp && last_bit) begin
                        state <= STOP;
                    end
                end
                STOP: begin
                    if (bit_smp) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if ((state == IDLE) || (state == WAIT) || start_smp || bit_smp) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bit_cnt <= '0;
        end else if (state != DATA) begin
            bit_cnt <= '0;
        end else if (bit_smp) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // data arrives LSB first, so it shifts in from the top.
    always_ff @(posedge clk_i) begin
        if ((state == DATA) && bit_smp) begin
            shift_q <= {rx_s, shift_q[`UART_DATA_WIDTH-1:1]};
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state == STOP) && bit_smp) begin
            frame_q.data      <= shift_q;
            frame_q.frame_err <= ~rx_s;
        end
    end

    assign frame_o       = frame_q;
    assign frame_valid_o = (state == WAIT); // one cycle after the stop sample.

endmodule

//--- frame_fifo.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module frame_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_i,
    input  logic     arstn_i,
    input  logic     push_i,
    input  logic     pop_i,
    input  payload_t data_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     full_o,
    output logic     overflow_o
);

    localparam int DEPTH = `UART_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    payload_t       mem [DEPTH];
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           do_push;
    logic           do_pop;

    // the top pointer bit tells a full buffer from an empty one.
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign do_push    = push_i && !full_o;
    assign do_pop     = pop_i && !empty_o;
    assign overflow_o = push_i && full_o; // the pushed entry is lost.

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr[PTR_W-1:0]] <= data_i;
        end
    end

    assign data_o = mem[rd_ptr[PTR_W-1:0]]; // head is read without delay.

endmodule

//--- rx_merge.sv
`timescale 1ns/1ps

module rx_merge (
    input  logic                    clk_i,
    input  logic                    arstn_i,
    input  uart_pkg::rx_frame_t     ch0_frame_i,
    input  uart_pkg::rx_frame_t     ch1_frame_i,
    input  logic                    ch0_empty_i,
    input  logic                    ch1_empty_i,
    input  logic                    out_full_i,
    output logic                    ch0_pop_o,
    output logic                    ch1_pop_o,
    output logic                    out_push_o,
    output uart_pkg::tagged_frame_t out_frame_o
);

    import uart_pkg::*;

    logic      last_q;    // channel that was served last.
    rx_frame_t sel_frame;

    // ****************************************
    // round-robin grant
    // ****************************************

    // a channel wins if it has data and the other one is idle or had the last turn.
    assign ch0_pop_o = !out_full_i && !ch0_empty_i && (ch1_empty_i || last_q);
    assign ch1_pop_o = !out_full_i && !ch1_empty_i && (ch0_empty_i || !last_q);

    assign out_push_o = ch0_pop_o || ch1_pop_o;

    assign sel_frame = ch1_pop_o ? ch1_frame_i : ch0_frame_i;

    assign out_frame_o.chan  = ch1_pop_o;
    assign out_frame_o.frame = sel_frame;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            last_q <= 1'b1; // channel 0 goes first after reset.
        end else if (out_push_o) begin
            last_q <= ch1_pop_o;
        end
    end

endmodule

//--- dual_uart_rx_top.sv
`timescale 1ns/1ps

module dual_uart_rx_top (
    input  logic                    clk_i,
    input  logic                    arstn_i,
    input  logic [1:0]              rx_i,
    output uart_pkg::tagged_frame_t m_frame_o,
    output logic                    m_valid_o,
    input  logic                    m_ready_i,
    output logic [1:0]              overrun_o
);

    import uart_pkg::*;

    rx_frame_t     rx_frame [2];
    logic [1:0]    rx_valid;
    rx_frame_t     ch_head [2];
    logic [1:0]    ch_empty;
    logic [1:0]    ch_pop;
    logic [1:0]    ch_ovf;
    tagged_frame_t merge_frame;
    logic          merge_push;
    logic          out_full;
    logic          out_empty;
    logic          out_pop;
    logic [1:0]    overrun_q;

    // ****************************************
    // receive channels
    // ****************************************

    for (genvar i = 0; i < 2; i++) begin : g_chan
        uart_rx u_rx (
            .clk_i         (clk_i),
            .arstn_i       (arstn_i),
            .rx_i          (rx_i[i]),
            .frame_o       (rx_frame[i]),
            .frame_valid_o (rx_valid[i])
        );

        // the line cannot wait, so a full FIFO only reports the loss.
        frame_fifo #(.payload_t(rx_frame_t)) u_fifo (
            .clk_i      (clk_i),
            .arstn_i    (arstn_i),
            .push_i     (rx_valid[i]),
            .pop_i      (ch_pop[i]),
            .data_i     (rx_frame[i]),
            .data_o     (ch_head[i]),
            .empty_o    (ch_empty[i]),
            .full_o     (),
            .overflow_o (ch_ovf[i])
        );
    end

    rx_merge u_merge (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .ch0_frame_i (ch_head[0]),
        .ch1_frame_i (ch_head[1]),
        .ch0_empty_i (ch_empty[0]),
        .ch1_empty_i (ch_empty[1]),
        .out_full_i  (out_full),
        .ch0_pop_o   (ch_pop[0]),
        .ch1_pop_o   (ch_pop[1]),
        .out_push_o  (merge_push),
        .out_frame_o (merge_frame)
    );

    // ****************************************
    // output stream
    // ****************************************

    // the merger never pushes into a full output FIFO.
    frame_fifo #(.payload_t(tagged_frame_t)) u_out_fifo (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .push_i     (merge_push),
        .pop_i      (out_pop),
        .data_i     (merge_frame),
        .data_o     (m_frame_o),
        .empty_o    (out_empty),
        .full_o     (out_full),
        .overflow_o ()
    );

    assign m_valid_o = !out_empty;
    assign out_pop   = m_valid_o && m_ready_i;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            overrun_q <= '0;
        end else begin
            overrun_q <= overrun_q | ch_ovf; // stays set until reset.
        end
    end

    assign overrun_o = overrun_q;

endmodule

//--- dual_uart_rx_sva.sv
`timescale 1ns/1ps

module dual_uart_rx_sva (
    input logic                    clk_i,
    input logic                    arstn_i,
    input uart_pkg::tagged_frame_t m_frame_o,
    input logic                    m_valid_o,
    input logic                    m_ready_i,
    input logic [1:0]              overrun_o
);

    // ****************************************
    // stream handshake
    // ****************************************

    valid_hold: assert property (
        @(posedge clk_i) disable iff (!arstn_i)
        (m_valid_o && !m_ready_i) |=> m_valid_o
    ) else $error("m_valid_o dropped without a transfer.");

    data_hold: assert property (
        @(posedge clk_i) disable iff (!arstn_i)
        (m_valid_o && !m_ready_i) |=> $stable(m_frame_o)
    ) else $error("m_frame_o changed while stalled.");

    // ****************************************
    // reset and status
    // ****************************************

    reset_state: assert property (
        @(posedge clk_i)
        $rose(arstn_i) |-> (!m_valid_o && (overrun_o == 2'b00))
    ) else $error("outputs not clear after reset.");

    overrun_sticky: assert property (
        @(posedge clk_i) disable iff (!arstn_i)
        (($past(overrun_o) & ~overrun_o) == 2'b00)
    ) else $error("an overrun flag fell without reset.");

endmodule

bind dual_uart_rx_top dual_uart_rx_sva sva0 (
    .clk_i     (clk_i),
    .arstn_i   (arstn_i),
    .m_frame_o (m_frame_o),
    .m_valid_o (m_valid_o),
    .m_ready_i (m_ready_i),
    .overrun_o (overrun_o)
);

//--- tb_dual_uart_rx.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_dual_uart_rx;

    import uart_pkg::*;

    localparam int CLKS_PER_BIT = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int KEEP_LIMIT   = 2 * `UART_FIFO_DEPTH; // channel FIFO plus output FIFO.

    logic          clk_i;
    logic          arstn_i;
    logic [1:0]    rx_i;
    tagged_frame_t m_frame_o;
    logic          m_valid_o;
    logic          m_ready_i;
    logic [1:0]    overrun_o;

    rx_frame_t     exp0[$];
    rx_frame_t     exp1[$];
    logic [31:0]   pend0[$];
    logic [31:0]   pend1[$];
    integer        seed;
    int            stall_left;
    bit            stall_on;
    int            kept[2];
    int            cycle_cnt;
    int            cycle_limit;

    dual_uart_rx_top dut0 (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .rx_i      (rx_i),
        .m_frame_o (m_frame_o),
        .m_valid_o (m_valid_o),
        .m_ready_i (m_ready_i),
        .overrun_o (overrun_o)
    );

    always #10 clk_i = ~clk_i;

    // ****************************************
    // reporting
    // ****************************************

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // ****************************************
    // stream side
    // ****************************************

    always @(posedge clk_i) begin
        logic [31:0] r;
        #1;
        if (stall_left > 0) begin
            m_ready_i = 1'b0;
            stall_left--;
            if (stall_left == 0) begin
                stall_on = 1'b0;
            end
        end else begin
            r = $random(seed);
            m_ready_i = r[0];
        end
    end

    // outputs are sampled on the edge, inputs only move 1 ns later.
    always @(posedge clk_i) begin
        rx_frame_t want;
        if (arstn_i && m_valid_o && m_ready_i) begin
            if (m_frame_o.chan) begin
                assert (exp1.size() > 0)
                    else report_mismatch("unexpected frame on channel 1");
                want = exp1.pop_front();
            end else begin
                assert (exp0.size() > 0)
                    else report_mismatch("unexpected frame on channel 0");
                want = exp0.pop_front();
            end
            assert (m_frame_o.frame == want)
                else report_mismatch($sformatf("chan %0d got %h err %b, expected %h err %b",
                    m_frame_o.chan, m_frame_o.frame.data, m_frame_o.frame.frame_err,
                    want.data, want.frame_err));
        end
    end

    // ****************************************
    // line drivers
    // ****************************************

    task automatic hold_line(input int ch, input logic v, input int clocks);
        @(posedge clk_i);
        #1 rx_i[ch] = v;
        repeat (clocks - 1) @(posedge clk_i);
    endtask

    task automatic expect_frame(input int ch, input logic [7:0] data, input logic stop);
        rx_frame_t f;
        f.data      = data;
        f.frame_err = ~stop;
        // a burst during a stall keeps only what the two FIFOs can hold.
        if (stall_on && (kept[ch] >= KEEP_LIMIT)) begin
            return;
        end
        if (stall_on) begin
            kept[ch]++;
        end
        if (ch == 0) begin
            exp0.push_back(f);
        end else begin
            exp1.push_back(f);
        end
    endtask

    task automatic send_frame(input int ch, input logic [7:0] data, input logic stop,
                              input int gap);
        expect_frame(ch, data, stop);
        hold_line(ch, 1'b0, CLKS_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            hold_line(ch, data[i], CLKS_PER_BIT); // LSB first.
        end
        hold_line(ch, stop, CLKS_PER_BIT);
        if (gap > 0) begin
            hold_line(ch, 1'b1, gap * CLKS_PER_BIT);
        end else begin
            @(posedge clk_i);
            #1 rx_i[ch] = 1'b1;
        end
    endtask

    task automatic send_glitch(input int ch, input int len);
        hold_line(ch, 1'b0, len);
        hold_line(ch, 1'b1, 3 * CLKS_PER_BIT);
    endtask

    task automatic drive_pending(input int ch);
        logic [31:0] e;
        while ((ch == 0) ? (pend0.size() > 0) : (pend1.size() > 0)) begin
            e = (ch == 0) ? pend0.pop_front() : pend1.pop_front();
            send_frame(ch, e[15:8], e[16], int'(e[7:0]));
        end
    endtask

    task automatic wait_drain();
        while ((exp0.size() > 0) || (exp1.size() > 0)) begin
            @(posedge clk_i);
        end
        repeat (5) @(posedge clk_i);
    endtask

    // ****************************************
    // test file
    // ****************************************

    // every command is counted as if it ran alone, which bounds the run.
    task automatic size_tests();
        int    fd;
        int    a;
        int    b;
        int    c;
        int    d;
        string line;
        cycle_limit = 5000;
        fd = $fopen("dual_uart_rx_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file dual_uart_rx_tests.txt");
            $display("Simulation failed");
            $fatal(1);
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 1) continue;
            void'($sscanf(line.substr(1, line.len() - 1), "%d %h %d %d", a, b, c, d));
            case (line.getc(0))
                "F": cycle_limit += (10 + d) * CLKS_PER_BIT + 10;
                "G": cycle_limit += 4 * CLKS_PER_BIT;
                "S": cycle_limit += a;
                default: cycle_limit += 10;
            endcase
        end
        $fclose(fd);
    endtask

    task automatic run_tests();
        int    fd;
        int    a;
        int    b;
        int    c;
        int    d;
        bit    par;
        string line;
        par = 1'b0;
        fd = $fopen("dual_uart_rx_tests.txt", "r");
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 1) continue;
            void'($sscanf(line.substr(1, line.len() - 1), "%d %h %d %d", a, b, c, d));
            case (line.getc(0))
                "F": begin
                    if (par && (a == 0)) begin
                        pend0.push_back({15'd0, c[0], b[7:0], d[7:0]});
                    end else if (par) begin
                        pend1.push_back({15'd0, c[0], b[7:0], d[7:0]});
                    end else begin
                        send_frame(a, b[7:0], c[0], d);
                    end
                end
                "G": send_glitch(a, b);
                "P": par = 1'b1;
                "J": begin
                    fork
                        drive_pending(0);
                        drive_pending(1);
                    join
                    par = 1'b0;
                end
                "S": begin
                    wait_drain();
                    kept[0] = 0;
                    kept[1] = 0;
                    stall_on = 1'b1;
                    stall_left = a;
                end
                "O": begin
                    wait_drain();
                    assert (overrun_o[a] == b[0])
                        else report_mismatch($sformatf("overrun_o[%0d] is %b, expected %0d",
                            a, overrun_o[a], b));
                end
                default: ; // comment lines.
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        clk_i      = 1'b0;
        arstn_i    = 1'b0;
        rx_i       = 2'b11;
        m_ready_i  = 1'b0;
        seed       = 32'hd397_cb5e;
        stall_left = 0;
        stall_on   = 1'b0;
        cycle_cnt  = 0;
        size_tests();
        repeat (4) @(posedge clk_i);
        #1 arstn_i = 1'b1;
        run_tests();
        wait_drain();
        assert (!m_valid_o)
            else report_mismatch("a frame was left in the output stream after the last one");
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- dual_uart_rx_tests.txt
# code and fields: F ch byte(hex) stop gap(bits) | G ch clocks | S clocks
# P starts a two-channel section, J runs it | O ch overrun flag
F 0 a5 1 1
F 1 3c 1 1
F 0 00 1 1
F 1 ff 1 2
# low stop bit gives a framing error
F 0 5a 0 2
F 1 81 0 2
# short low pulses must be ignored
G 0 3
G 1 4
G 0 1
F 0 7e 1 1
# both lines at once
P
F 0 11 1 0
F 0 22 1 1
F 0 33 1 0
F 0 44 1 2
F 1 91 1 1
F 1 92 1 0
F 1 93 1 0
F 1 94 1 1
J
O 0 0
O 1 0
# burst on channel 0 while the output is stalled
S 1500
F 0 c0 1 0
F 0 c1 1 0
F 0 c2 1 0
F 0 c3 1 0
F 0 c4 1 0
F 0 c5 1 0
F 0 c6 1 0
F 0 c7 1 0
F 0 c8 1 0
F 0 c9 1 0
F 0 ca 1 0
F 0 cb 1 1
O 0 1
O 1 0
F 1 e7 1 1

//--- tb.f
+incdir+.
uart_pkg.sv
uart_rx.sv
frame_fifo.sv
rx_merge.sv
dual_uart_rx_top.sv
dual_uart_rx_sva.sv
tb_dual_uart_rx.sv

//--- run.sh
#!/bin/sh
# builds and runs the dual UART receiver testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dual_uart_rx -f tb.f -o sim_dual_uart \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_dual_uart | tee /dev/stderr | grep -q "Simulation passed" \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }
